//--- Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - include
    files:
      - hdl/decodePkg.sv
      - hdl/regAccessIf.sv
      - hdl/regFileBypass.sv
      - hdl/controlDecoder.sv
      - hdl/aluControl.sv
      - hdl/decodeStage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/decodeChecker.sv
      - bench/decodeStageTb.sv

//--- bench/decodeChecker.sv
// Watches the decode stage and compares every output at the falling edge.
// Expected values come from a shadow register file and reference decode functions.
`timescale 1ns/10ps
`default_nettype none

`include "decode_params.svh"

module decodeChecker (
    input logic clk,
    input logic rstN,
    input logic [`DATA_WIDTH-1:0] instr,
    input logic nopMech,
    input logic fetchErr,
    input logic wbEn,
    input logic [`REG_SEL_WIDTH-1:0] wbSel,
    input logic [`DATA_WIDTH-1:0] wbData,
    input logic valid,
    input logic [`DATA_WIDTH-1:0] rsData, rtData,
    input logic [`DATA_WIDTH-1:0] imm5, imm8, sImm8, sImm11,
    input logic [`REG_SEL_WIDTH-1:0] rd,
    input logic [3:0] oper,
    input logic invA, invB, cin,
    input logic regWrt, memRead, memWrt, immSrc, aluJmp,
    input logic [1:0] bSrc, regSrc, branchType,
    input logic nop, nHalt, branchNop, err,
    output int errorCount
);

    localparam logic [2:0] SelAdd = 3'd0;
    localparam logic [2:0] SelSub = 3'd1;
    localparam logic [2:0] SelXor = 3'd2;
    localparam logic [2:0] SelAndn = 3'd3;
    localparam logic [2:0] SelPassB = 3'd4;

    typedef struct packed {
        logic [1:0] regDst;
        logic regWrt, memRead, memWrt, zeroExt, immSrc;
        logic [1:0] bSrc;
        logic [1:0] regSrc;
        logic aluJmp;
        logic [1:0] branchType;
        logic nop, nHalt, illegal;
        logic [3:0] oper;
        logic invA, invB, cin;
    } expCtrlT;

    logic [`DATA_WIDTH-1:0] shadow [`REG_COUNT];
    logic started = 1'b0;
    logic expValid;
    expCtrlT expC;
    logic [4*`DATA_WIDTH-1:0] expImm;
    logic [`REG_SEL_WIDTH-1:0] expRd;
    logic [`DATA_WIDTH-1:0] expRs;
    logic [`DATA_WIDTH-1:0] expRt;

    initial errorCount = 0;

    // Control bundle and ALU mapping for one opcode
    function automatic expCtrlT decodeRef(logic [4:0] opIn, logic [1:0] func, logic forceNop);
        expCtrlT e;
        logic [4:0] op;
        logic [2:0] aluSel;
        e = '0;
        e.nHalt = 1'b1;
        aluSel = SelAdd;
        op = forceNop ? 5'b00001 : opIn;
        case (op)
            5'b00000: e.nHalt = 1'b0;
            5'b00001: e.nop = 1'b1;
            5'b00100: begin
                e.immSrc = 1'b1;
                e.aluJmp = 1'b1;
                e.branchType = 2'b11;
            end
            5'b01000, 5'b01001, 5'b01010, 5'b01011: begin
                e.regWrt = 1'b1;
                e.bSrc = 2'b01;
                case (op)
                    5'b01000: aluSel = SelAdd;
                    5'b01001: aluSel = SelSub;
                    5'b01010: aluSel = SelXor;
                    default: aluSel = SelAndn;
                endcase
                // XORI and ANDNI take an unsigned immediate
                e.zeroExt = (aluSel == SelXor) || (aluSel == SelAndn);
            end
            5'b01100, 5'b01101: begin
                e.bSrc = 2'b11;
                e.branchType = op[0] ? 2'b10 : 2'b01;
            end
            5'b10000: begin
                e.memWrt = 1'b1;
                e.bSrc = 2'b01;
            end
            5'b10001: begin
                e.regWrt = 1'b1;
                e.memRead = 1'b1;
                e.bSrc = 2'b01;
                e.regSrc = 2'b01;
            end
            5'b10010, 5'b11000: begin
                e.regDst = 2'b01;
                e.regWrt = 1'b1;
                e.bSrc = 2'b10;
                e.zeroExt = (op == 5'b10010);
                aluSel = SelPassB;
            end
            5'b11011: begin
                e.regDst = 2'b10;
                e.regWrt = 1'b1;
                // Function field order is ADD, SUB, XOR, ANDN
                aluSel = {1'b0, func};
            end
            default: e.illegal = 1'b1;
        endcase
        e.oper = `OPER_ADD;
        case (aluSel)
            SelSub: begin
                e.invA = 1'b1;
                e.cin = 1'b1;
            end
            SelXor: e.oper = `OPER_XOR;
            SelAndn: begin
                e.oper = `OPER_AND;
                e.invB = 1'b1;
            end
            SelPassB: e.oper = `OPER_PASSB;
            default: e.oper = `OPER_ADD;
        endcase
        return e;
    endfunction

    // Packed as imm5, imm8, sImm8, sImm11
    function automatic logic [63:0] immRef(logic [15:0] ins, logic zeroExt);
        logic [15:0] i5;
        logic [15:0] i8;
        logic [15:0] s8;
        logic [15:0] s11;
        s8 = {{8{ins[7]}}, ins[7:0]};
        s11 = {{5{ins[10]}}, ins[10:0]};
        i5 = zeroExt ? {11'b0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
        i8 = zeroExt ? {8'b0, ins[7:0]} : s8;
        return {i5, i8, s8, s11};
    endfunction

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        started <= 1'b1;
        expValid <= rstN;
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow[i] <= '0;
            end
        end else if (wbEn) begin
            shadow[wbSel] <= wbData;
        end
    end

    always @(negedge clk) begin
        if (started) begin
            expC = decodeRef(instr[15:11], instr[1:0], nopMech);
            expImm = immRef(instr, expC.zeroExt);
            case (expC.regDst)
                2'b00: expRd = instr[7:5];
                2'b01: expRd = instr[10:8];
                2'b10: expRd = instr[4:2];
                default: expRd = 3'd7;
            endcase
            // Same-cycle write-back is forwarded
            expRs = (wbEn && wbSel == instr[10:8]) ? wbData : shadow[instr[10:8]];
            expRt = (wbEn && wbSel == instr[7:5]) ? wbData : shadow[instr[7:5]];

            checkValue("valid", expValid, valid);
            checkValue("rsData", expRs, rsData);
            checkValue("rtData", expRt, rtData);
            checkValue("imm5", expImm[63:48], imm5);
            checkValue("imm8", expImm[47:32], imm8);
            checkValue("sImm8", expImm[31:16], sImm8);
            checkValue("sImm11", expImm[15:0], sImm11);
            checkValue("rd", expRd, rd);
            checkValue("oper", expC.oper, oper);
            checkValue("invA", expC.invA, invA);
            checkValue("invB", expC.invB, invB);
            checkValue("cin", expC.cin, cin);
            checkValue("regWrt", expC.regWrt, regWrt);
            checkValue("memRead", expC.memRead, memRead);
            checkValue("memWrt", expC.memWrt, memWrt);
            checkValue("immSrc", expC.immSrc, immSrc);
            checkValue("bSrc", expC.bSrc, bSrc);
            checkValue("regSrc", expC.regSrc, regSrc);
            checkValue("aluJmp", expC.aluJmp, aluJmp);
            checkValue("branchType", expC.branchType, branchType);
            checkValue("nop", expC.nop, nop);
            checkValue("nHalt", expC.nHalt, nHalt);
            checkValue("branchNop", expC.branchType != 2'b00, branchNop);
            checkValue("err", expC.illegal | fetchErr, err);
        end
    end

endmodule

`default_nettype wire

//--- bench/decodeStageTb.sv
// Testbench top for the decode stage. Inputs change 1 ns after the rising edge,
// the checker compares at the falling edge. Random stimulus uses a fixed seed.
`timescale 1ns/10ps
`default_nettype none

`include "decode_params.svh"

module decodeStageTb;

    localparam int RandSeed = 32'h8969;
    // About 700 cycles of tests, with margin on top
    localparam int CycleLimit = 1000;
    localparam logic [4:0] OpNop = 5'b00001;

    logic clk;
    logic rstN;
    logic [`DATA_WIDTH-1:0] instr;
    logic nopMech, fetchErr, wbEn;
    logic [`REG_SEL_WIDTH-1:0] wbSel;
    logic [`DATA_WIDTH-1:0] wbData;
    logic valid;
    logic [`DATA_WIDTH-1:0] rsData, rtData;
    logic [`DATA_WIDTH-1:0] imm5, imm8, sImm8, sImm11;
    logic [`REG_SEL_WIDTH-1:0] rd;
    logic [3:0] oper;
    logic invA, invB, cin;
    logic regWrt, memRead, memWrt, immSrc, aluJmp;
    logic [1:0] bSrc, regSrc, branchType;
    logic nop, nHalt, branchNop, err;
    int errorCount;
    int cycleCount = 0;
    int testsPassed = 0;
    int testsFailed = 0;

    decodeStage u_dut (.*);

    decodeChecker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic drive(input logic [15:0] ins, input logic nm, input logic fe,
                         input logic we, input logic [2:0] ws, input logic [15:0] wd);
        @(posedge clk);
        #1;
        instr = ins;
        nopMech = nm;
        fetchErr = fe;
        wbEn = we;
        wbSel = ws;
        wbData = wd;
    endtask

    // Waits until the last driven cycle has been checked
    task automatic finishTest(input string name, input int errorsBefore);
        int found;
        @(negedge clk);
        #1;
        found = errorCount - errorsBefore;
        if (found == 0) begin
            testsPassed++;
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: %0d mismatches", name, found);
        end
    endtask

    initial begin
        int startErrors;
        logic [2:0] sel;
        logic [15:0] ins;
        void'($urandom(RandSeed));
        rstN = 1'b0;
        instr = '0;
        nopMech = 1'b0;
        fetchErr = 1'b0;
        wbEn = 1'b0;
        wbSel = '0;
        wbData = '0;

        repeat (4) @(posedge clk);
        #1 rstN = 1'b1;
        for (int i = 0; i < 8; i++) begin
            drive({OpNop, i[2:0], 3'(7 - i), 5'b0}, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0);
        end
        finishTest("reset", 0);

        startErrors = errorCount;
        repeat (100) drive(16'($urandom), 1'b0, 1'b0, 1'b1, 3'($urandom), 16'($urandom));
        for (int i = 0; i < 64; i++) begin
            drive({OpNop, i[5:3], i[2:0], 5'b0}, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0);
        end
        finishTest("write then read", startErrors);

        // Alternate the port that hits the write-back register
        startErrors = errorCount;
        for (int i = 0; i < 50; i++) begin
            sel = 3'($urandom);
            ins = (i % 2 == 0) ? {OpNop, sel, 3'($urandom), 5'b0} :
                                 {OpNop, 3'($urandom), sel, 5'b0};
            drive(ins, 1'b0, 1'b0, 1'b1, sel, 16'($urandom));
        end
        finishTest("forwarding", startErrors);

        startErrors = errorCount;
        repeat (200) drive(16'($urandom), 1'b0, 1'b0, 1'b0, 3'd0, 16'h0);
        finishTest("immediates", startErrors);

        startErrors = errorCount;
        for (int op = 0; op < 32; op++) begin
            for (int f = 0; f < 4; f++) begin
                drive({op[4:0], 9'($urandom), f[1:0]}, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0);
            end
        end
        finishTest("control decode", startErrors);

        // Forced NOP first, then fetch errors on a legal ADDI
        startErrors = errorCount;
        repeat (64) drive(16'($urandom), 1'b1, 1'b0, 1'b0, 3'd0, 16'h0);
        repeat (32) drive({5'b01000, 11'($urandom)}, 1'b0, 1'b1, 1'b0, 3'd0, 16'h0);
        finishTest("overrides", startErrors);

        $display("Tests: %0d ok, %0d with mismatches, %0d mismatches in all",
                 testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- decodeStage.f
+incdir+include
hdl/decodePkg.sv
hdl/regAccessIf.sv
hdl/regFileBypass.sv
hdl/controlDecoder.sv
hdl/aluControl.sv
hdl/decodeStage.sv
bench/decodeChecker.sv
bench/decodeStageTb.sv

//--- hdl/aluControl.sv
// Maps an ALU operation to operator code, operand inversion and carry-in.
// SUB computes B - A, so A is inverted.
`timescale 1ns/10ps
`default_nettype none

`include "decode_params.svh"

module aluControl (
    input decodePkg::aluOpE aluOp,
    input logic [1:0] func,
    input logic rAlu,
    output logic [3:0] oper,
    output logic invA,
    output logic invB,
    output logic cin
);

    decodePkg::aluOpE effOp;

    // Function field values line up with the first four ALU operations
    assign effOp = rAlu ? decodePkg::aluOpE'({1'b0, func}) : aluOp;

    always_comb begin
        oper = `OPER_ADD;
        invA = 1'b0;
        invB = 1'b0;
        cin = 1'b0;

        case (effOp)
            decodePkg::ALU_SUB: begin
                invA = 1'b1;
                cin = 1'b1;
            end
            decodePkg::ALU_XOR: oper = `OPER_XOR;
            decodePkg::ALU_ANDN: begin
                oper = `OPER_AND;
                invB = 1'b1;
            end
            decodePkg::ALU_PASSB: oper = `OPER_PASSB;
            default: oper = `OPER_ADD;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/controlDecoder.sv
// Opcode decoder. Purely combinational.
// nopMech overrides the instruction with a NOP, unknown opcodes raise illegal.
`timescale 1ns/10ps
`default_nettype none

module controlDecoder (
    input decodePkg::instrU instr,
    input logic nopMech,
    output decodePkg::ctrlS ctrl,
    output logic nop,
    output logic nHalt,
    output logic illegal
);

    decodePkg::opcodeE opcode;

    assign opcode = nopMech ? decodePkg::OP_NOP : instr.rFmt.opcode;

    always_comb begin
        // No writes, no branch unless an opcode says otherwise
        ctrl = '0;
        ctrl.aluOp = decodePkg::ALU_ADD;
        ctrl.branchType = decodePkg::BR_NONE;
        nop = 1'b0;
        nHalt = 1'b1;
        illegal = 1'b0;

        case (opcode)
            decodePkg::OP_HALT: begin
                nHalt = 1'b0;
            end
            decodePkg::OP_NOP: begin
                nop = 1'b1;
            end
            decodePkg::OP_J: begin
                ctrl.immSrc = 1'b1;
                ctrl.aluJmp = 1'b1;
                ctrl.branchType = decodePkg::BR_JUMP;
            end
            decodePkg::OP_ADDI, decodePkg::OP_SUBI,
            decodePkg::OP_XORI, decodePkg::OP_ANDNI: begin
                ctrl.regDst = 2'b00;
                ctrl.regWrt = 1'b1;
                ctrl.bSrc = 2'b01;
                // Logic immediates are zero-extended
                ctrl.zeroExt = (opcode == decodePkg::OP_XORI) ||
                               (opcode == decodePkg::OP_ANDNI);
                ctrl.aluOp = decodePkg::aluOpE'({1'b0, opcode[1:0]});
            end
            decodePkg::OP_BEQZ, decodePkg::OP_BNEZ: begin
                // rs passes the ALU unchanged for the zero test
                ctrl.bSrc = 2'b11;
                ctrl.branchType = (opcode == decodePkg::OP_BEQZ) ?
                                  decodePkg::BR_EQZ : decodePkg::BR_NEZ;
            end
            decodePkg::OP_ST: begin
                ctrl.memWrt = 1'b1;
                ctrl.bSrc = 2'b01;
            end
            decodePkg::OP_LD: begin
                ctrl.regDst = 2'b00;
                ctrl.regWrt = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.bSrc = 2'b01;
                ctrl.regSrc = 2'b01;
            end
            decodePkg::OP_SLBI, decodePkg::OP_LBI: begin
                ctrl.regDst = 2'b01;
                ctrl.regWrt = 1'b1;
                ctrl.bSrc = 2'b10;
                ctrl.zeroExt = (opcode == decodePkg::OP_SLBI);
                ctrl.aluOp = decodePkg::ALU_PASSB;
            end
            decodePkg::OP_RALU: begin
                // Operation itself comes from the function field
                ctrl.regDst = 2'b10;
                ctrl.regWrt = 1'b1;
                ctrl.bSrc = 2'b00;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/decodePkg.sv
// Types for the decode stage. Opcodes sit in bits 15..11 in every format.
// Opcodes that are not listed in opcodeE are illegal.
`default_nettype none

`include "decode_params.svh"

package decodePkg;

    typedef logic [`DATA_WIDTH-1:0] wordT;

    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_LBI   = 5'b11000,
        OP_RALU  = 5'b11011
    } opcodeE;

    // Order matches the R-format function field for the first four
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_XOR   = 3'd2,
        ALU_ANDN  = 3'd3,
        ALU_PASSB = 3'd4
    } aluOpE;

    typedef enum logic [1:0] {
        BR_NONE = 2'b00,
        BR_EQZ  = 2'b01,
        BR_NEZ  = 2'b10,
        BR_JUMP = 2'b11
    } branchE;

    typedef struct packed {
        opcodeE opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] func;
    } rFmtS;

    typedef struct packed {
        opcodeE opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm5;
    } iFmtS;

    typedef struct packed {
        opcodeE opcode;
        logic [10:0] imm11;
    } jFmtS;

    typedef union packed {
        rFmtS rFmt;
        iFmtS iFmt;
        jFmtS jFmt;
    } instrU;

    // regDst: 00 bits 7..5, 01 bits 10..8, 10 bits 4..2, 11 register 7
    // bSrc: 00 rt data, 01 imm5, 10 imm8, 11 zero
    // regSrc: 00 ALU result, 01 memory data, 10 return address
    typedef struct packed {
        logic [1:0] regDst;
        logic regWrt;
        logic memRead;
        logic memWrt;
        logic zeroExt;
        logic immSrc;
        logic [1:0] bSrc;
        aluOpE aluOp;
        logic aluJmp;
        logic [1:0] regSrc;
        branchE branchType;
    } ctrlS;

endpackage

`default_nettype wire

//--- hdl/decodeStage.sv
// Decode stage top. All decode outputs are combinational from instr.
// valid rises at the first clock edge after reset is released.
`timescale 1ns/10ps
`default_nettype none

`include "decode_params.svh"

module decodeStage (
    input logic clk,
    input logic rstN,
    input logic [`DATA_WIDTH-1:0] instr,
    input logic nopMech,
    input logic fetchErr,
    input logic wbEn,
    input logic [`REG_SEL_WIDTH-1:0] wbSel,
    input logic [`DATA_WIDTH-1:0] wbData,
    output logic valid,
    output logic [`DATA_WIDTH-1:0] rsData,
    output logic [`DATA_WIDTH-1:0] rtData,
    output logic [`DATA_WIDTH-1:0] imm5,
    output logic [`DATA_WIDTH-1:0] imm8,
    output logic [`DATA_WIDTH-1:0] sImm8,
    output logic [`DATA_WIDTH-1:0] sImm11,
    output logic [`REG_SEL_WIDTH-1:0] rd,
    output logic [3:0] oper,
    output logic invA,
    output logic invB,
    output logic cin,
    output logic regWrt,
    output logic memRead,
    output logic memWrt,
    output logic immSrc,
    output logic [1:0] bSrc,
    output logic [1:0] regSrc,
    output logic aluJmp,
    output logic [1:0] branchType,
    output logic nop,
    output logic nHalt,
    output logic branchNop,
    output logic err
);

    decodePkg::instrU instrW;
    decodePkg::ctrlS ctrl;
    logic illegal;
    logic rAlu;

    regAccessIf regBus ();

    assign instrW = instr;

    // Sources are fixed fields, write-back comes straight from the ports
    assign regBus.read1Sel = instrW.rFmt.rs;
    assign regBus.read2Sel = instrW.rFmt.rt;
    assign regBus.writeEn = wbEn;
    assign regBus.writeSel = wbSel;
    assign regBus.writeData = wbData;
    assign rsData = regBus.read1Data;
    assign rtData = regBus.read2Data;

    regFileBypass u_regFile (
        .clk(clk),
        .rstN(rstN),
        .port(regBus.file)
    );

    controlDecoder u_ctrlDec (
        .instr(instrW),
        .nopMech(nopMech),
        .ctrl(ctrl),
        .nop(nop),
        .nHalt(nHalt),
        .illegal(illegal)
    );

    // A forced NOP must not pick up the function field
    assign rAlu = !nopMech && (instrW.rFmt.opcode == decodePkg::OP_RALU);

    aluControl u_aluCtrl (
        .aluOp(ctrl.aluOp),
        .func(instrW.rFmt.func),
        .rAlu(rAlu),
        .oper(oper),
        .invA(invA),
        .invB(invB),
        .cin(cin)
    );

    always_comb begin
        case (ctrl.regDst)
            2'b00: rd = instrW.iFmt.rd;
            2'b01: rd = instrW.rFmt.rs;
            2'b10: rd = instrW.rFmt.rd;
            default: rd = 3'd7;
        endcase
    end

    assign imm5 = ctrl.zeroExt ? {{(`DATA_WIDTH-5){1'b0}}, instr[4:0]} :
                                 {{(`DATA_WIDTH-5){instr[4]}}, instr[4:0]};
    assign sImm8 = {{(`DATA_WIDTH-8){instr[7]}}, instr[7:0]};
    assign imm8 = ctrl.zeroExt ? {{(`DATA_WIDTH-8){1'b0}}, instr[7:0]} : sImm8;
    assign sImm11 = {{(`DATA_WIDTH-11){instr[10]}}, instr[10:0]};

    assign regWrt = ctrl.regWrt;
    assign memRead = ctrl.memRead;
    assign memWrt = ctrl.memWrt;
    assign immSrc = ctrl.immSrc;
    assign bSrc = ctrl.bSrc;
    assign regSrc = ctrl.regSrc;
    assign aluJmp = ctrl.aluJmp;
    assign branchType = ctrl.branchType;
    assign branchNop = (ctrl.branchType != decodePkg::BR_NONE);
    assign err = illegal | fetchErr;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            valid <= 1'b0;
        end else begin
            valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/regAccessIf.sv
// Register file access. Reads are combinational, the write is a strobe
// taken at the clock edge while writeEn is high.
`timescale 1ns/10ps
`default_nettype none

`include "decode_params.svh"

interface regAccessIf;
    logic [`REG_SEL_WIDTH-1:0] read1Sel;
    logic [`REG_SEL_WIDTH-1:0] read2Sel;
    logic [`DATA_WIDTH-1:0] read1Data;
    logic [`DATA_WIDTH-1:0] read2Data;
    logic writeEn;
    logic [`REG_SEL_WIDTH-1:0] writeSel;
    logic [`DATA_WIDTH-1:0] writeData;

    modport stage (
        output read1Sel, read2Sel, writeEn, writeSel, writeData,
        input read1Data, read2Data
    );

    modport file (
        input read1Sel, read2Sel, writeEn, writeSel, writeData,
        output read1Data, read2Data
    );
endinterface

`default_nettype wire

//--- hdl/regFileBypass.sv
// Eight-entry register file, cleared by reset.
// A write-back in the same cycle is forwarded to a matching read port.
`timescale 1ns/10ps
`default_nettype none

`include "decode_params.svh"

module regFileBypass (
    input logic clk,
    input logic rstN,
    regAccessIf.file port
);

    localparam int NumReadPorts = 2;

    decodePkg::wordT regs [`REG_COUNT];

    // Read ports as arrays so both come from one loop body
    logic [`REG_SEL_WIDTH-1:0] readSel [NumReadPorts];
    decodePkg::wordT readData [NumReadPorts];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (port.writeEn) begin
            regs[port.writeSel] <= port.writeData;
        end
    end

    assign readSel[0] = port.read1Sel;
    assign readSel[1] = port.read2Sel;

    generate
        for (genvar g = 0; g < NumReadPorts; g++) begin : genReadPort
            logic hit;

            // Write-back to the same register wins over storage
            assign hit = port.writeEn && (port.writeSel == readSel[g]);
            assign readData[g] = hit ? port.writeData : regs[readSel[g]];
        end
    endgenerate

    assign port.read1Data = readData[0];
    assign port.read2Data = readData[1];

endmodule

`default_nettype wire

//--- include/decode_params.svh
// Widths and register count shared by the decode stage and its bench.
// The ALU operator codes must match the encoding of the execute stage.
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define DATA_WIDTH 16
`define REG_COUNT 8
`define REG_SEL_WIDTH 3

// Operator codes sent to the ALU
// SUB runs as ADD with invA and cin, ANDN runs as AND with invB
`define OPER_ADD 4'b0000
`define OPER_XOR 4'b0001
`define OPER_AND 4'b0010
`define OPER_PASSB 4'b0011

`endif
